/* design/zx_pkg.sv */
package zx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// port addresses
	////////////////////////////////////////////////////////////////////////////

	// low address byte
	localparam logic [7:0] PORT_FE       = 8'hFE;
	localparam logic [7:0] PORT_SD_DATA  = 8'h57;
	localparam logic [7:0] PORT_SD_CTRL  = 8'h77;
	localparam logic [7:0] XPORT_LOW     = 8'hAF;

	// high address byte of the #xxAF ports
	localparam logic [7:0] XPORT_BORDER  = 8'h0F;
	localparam logic [7:0] XPORT_SYSCONF = 8'h20;
	localparam logic [7:0] XPORT_MEMCONF = 8'h21;
	localparam logic [7:0] XPORT_IM2VECT = 8'h24;

	// register values after reset
	localparam logic [7:0] BORDER_RST    = 8'h00;
	localparam logic [7:0] SYSCONF_RST   = 8'h00;
	localparam logic [7:0] MEMCONF_RST   = 8'h00;
	localparam logic [7:0] IM2VECT_RST   = 8'hFF;

	localparam int SYNC_STAGES = 2;
	localparam int SPI_BITS    = 8;

	////////////////////////////////////////////////////////////////////////////
	// bus types
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        iord;
		logic        iord_s;
		logic        iowr_s;
		logic        intack;
	} z80_bus_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

endpackage

/* design/z80_strobes.sv */
`timescale 1ns/1ps

module z80_strobes (
	input  logic              fclk,
	input  logic              rst_n,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic [15:0]       a,
	input  logic [7:0]        zd_in,
	output zx_pkg::z80_bus_t  bus
);

	import zx_pkg::*;

	// {iorq_n, rd_n, wr_n, m1_n}
	logic [3:0] ctl_n;
	logic [SYNC_STAGES-1:0][3:0] sync_q;
	logic [3:0] ctl_s;

	logic iorq, rd, wr, m1;
	logic iord_c, iowr_c, intack_c;

	logic iord_q, iowr_q, intack_q;
	logic iord_s_q, iowr_s_q;

	assign ctl_n = {iorq_n, rd_n, wr_n, m1_n};

	// control lines are idle high
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			sync_q <= '1;
		else
			sync_q <= {sync_q[SYNC_STAGES-2:0], ctl_n};
	end

	assign ctl_s = sync_q[SYNC_STAGES-1];

	assign iorq = ~ctl_s[3];
	assign rd   = ~ctl_s[2];
	assign wr   = ~ctl_s[1];
	assign m1   = ~ctl_s[0];

	assign iord_c   = iorq & rd & ~m1;
	assign iowr_c   = iorq & wr & ~m1;
	assign intack_c = iorq & m1;

	// levels plus start-of-cycle pulses
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			iord_q   <= 1'b0;
			iowr_q   <= 1'b0;
			intack_q <= 1'b0;
			iord_s_q <= 1'b0;
			iowr_s_q <= 1'b0;
		end else begin
			iord_q   <= iord_c;
			iowr_q   <= iowr_c;
			intack_q <= intack_c;
			iord_s_q <= iord_c & ~iord_q;
			iowr_s_q <= iowr_c & ~iowr_q;
		end
	end

	// address and data are stable for the whole bus cycle
	assign bus = '{
		addr:   a,
		wdata:  zd_in,
		iord:   iord_q,
		iord_s: iord_s_q,
		iowr_s: iowr_s_q,
		intack: intack_q
	};

endmodule

/* design/zports.sv */
`timescale 1ns/1ps

module zports (
	input  logic              fclk,
	input  logic              rst_n,
	input  zx_pkg::z80_bus_t  bus,
	input  zx_pkg::wb_rsp_t   wb_rsp,
	output zx_pkg::wb_req_t   wb_req,
	output logic [7:0]        zd_out,
	output logic              zd_oe,
	output logic [7:0]        border,
	output logic [1:0]        turbo,
	output logic [7:0]        memconf,
	output logic              beep,
	output logic              sdcs_n,
	output logic              wait_n
);

	import zx_pkg::*;

	logic [7:0] lo, hi;
	logic hit_fe, hit_xp, hit_sd_data, hit_sd_ctrl;
	logic hit_border, hit_sysconf, hit_memconf, hit_im2vect;

	logic [7:0] sysconf;
	logic [7:0] im2vect;
	logic [7:0] sd_byte;
	logic       sd_start;

	////////////////////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////////////////////

	assign lo = bus.addr[7:0];
	assign hi = bus.addr[15:8];

	assign hit_fe      = (lo == PORT_FE);
	assign hit_sd_data = (lo == PORT_SD_DATA);
	assign hit_sd_ctrl = (lo == PORT_SD_CTRL);
	assign hit_xp      = (lo == XPORT_LOW);

	assign hit_border  = hit_xp && (hi == XPORT_BORDER);
	assign hit_sysconf = hit_xp && (hi == XPORT_SYSCONF);
	assign hit_memconf = hit_xp && (hi == XPORT_MEMCONF);
	assign hit_im2vect = hit_xp && (hi == XPORT_IM2VECT);

	////////////////////////////////////////////////////////////////////////////
	// configuration registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			border  <= BORDER_RST;
			sysconf <= SYSCONF_RST;
			memconf <= MEMCONF_RST;
			im2vect <= IM2VECT_RST;
			beep    <= 1'b0;
			sdcs_n  <= 1'b1;
		end else if (bus.iowr_s) begin
			// #FE only carries 3 border bits
			if (hit_fe) begin
				border <= {5'b11110, bus.wdata[2:0]};
				beep   <= bus.wdata[4];
			end
			if (hit_border)
				border <= bus.wdata;
			if (hit_sysconf)
				sysconf <= bus.wdata;
			if (hit_memconf)
				memconf <= bus.wdata;
			if (hit_im2vect)
				im2vect <= bus.wdata;
			if (hit_sd_ctrl)
				sdcs_n <= bus.wdata[1];
		end
	end

	assign turbo = sysconf[1:0];

	////////////////////////////////////////////////////////////////////////////
	// SD access over Wishbone, Z80 held in wait meanwhile
	////////////////////////////////////////////////////////////////////////////

	assign sd_start = (bus.iowr_s | bus.iord_s) & hit_sd_data;

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			wb_req <= '0;
			wait_n <= 1'b1;
		end else if (wb_req.cyc) begin
			if (wb_rsp.ack) begin
				wb_req.cyc <= 1'b0;
				wb_req.stb <= 1'b0;
				wait_n     <= 1'b1;
			end
		end else if (sd_start) begin
			wb_req.cyc <= 1'b1;
			wb_req.stb <= 1'b1;
			wb_req.we  <= bus.iowr_s;
			wb_req.dat <= bus.wdata;
			wait_n     <= 1'b0;
		end
	end

	// byte returned by the last exchange or read
	always_ff @(posedge fclk) begin
		if (wb_req.cyc && wb_rsp.ack)
			sd_byte <= wb_rsp.dat;
	end

	////////////////////////////////////////////////////////////////////////////
	// read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		zd_oe  = 1'b0;
		zd_out = 8'h00;
		if (bus.intack) begin
			zd_oe  = 1'b1;
			zd_out = im2vect;
		end else if (bus.iord) begin
			if (hit_border) begin
				zd_oe  = 1'b1;
				zd_out = border;
			end else if (hit_sysconf) begin
				zd_oe  = 1'b1;
				zd_out = sysconf;
			end else if (hit_memconf) begin
				zd_oe  = 1'b1;
				zd_out = memconf;
			end else if (hit_sd_data) begin
				zd_oe  = 1'b1;
				zd_out = sd_byte;
			end
		end
	end

endmodule

/* design/sd_spi.sv */
`timescale 1ns/1ps

module sd_spi (
	input  logic             fclk,
	input  logic             rst_n,
	input  zx_pkg::wb_req_t  wb_req,
	input  logic             sddi,
	output zx_pkg::wb_rsp_t  wb_rsp,
	output logic             sdclk,
	output logic             sddo
);

	import zx_pkg::*;

	typedef logic [$clog2(SPI_BITS):0] cnt_t;

	logic                busy;
	logic                ack;
	cnt_t                bit_cnt;
	logic [SPI_BITS-1:0] tx_sh;
	logic [SPI_BITS-1:0] rx_sh;
	logic [SPI_BITS-1:0] rx_byte;
	logic                done;

	// all bits clocked out, final falling edge already seen
	assign done = (bit_cnt == cnt_t'(SPI_BITS));

	////////////////////////////////////////////////////////////////////////////
	// mode 0 engine, sdclk at half fclk
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			ack     <= 1'b0;
			sdclk   <= 1'b0;
			bit_cnt <= '0;
			tx_sh   <= '0;
		end else begin
			ack <= 1'b0;
			if (busy) begin
				if (done) begin
					busy <= 1'b0;
					ack  <= 1'b1;
				end else if (!sdclk) begin
					sdclk <= 1'b1;
				end else begin
					// next bit goes out with the falling edge
					sdclk   <= 1'b0;
					tx_sh   <= {tx_sh[SPI_BITS-2:0], 1'b0};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (wb_req.cyc && wb_req.stb && !ack) begin
				if (wb_req.we) begin
					busy    <= 1'b1;
					tx_sh   <= wb_req.dat;
					bit_cnt <= '0;
				end else begin
					ack <= 1'b1;
				end
			end
		end
	end

	// sample on the rising sdclk edge
	always_ff @(posedge fclk) begin
		if (busy && !done && !sdclk)
			rx_sh <= {rx_sh[SPI_BITS-2:0], sddi};
		if (busy && done)
			rx_byte <= rx_sh;
	end

	assign sddo = tx_sh[SPI_BITS-1];

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rx_byte;

endmodule

/* design/zx_port_top.sv */
`timescale 1ns/1ps

module zx_port_top (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic [15:0] a,
	input  logic [7:0]  zd_in,
	input  logic        sddi,
	output logic [7:0]  zd_out,
	output logic        zd_oe,
	output logic        wait_n,
	output logic [7:0]  border,
	output logic [1:0]  turbo,
	output logic [7:0]  memconf,
	output logic        beep,
	output logic        sdcs_n,
	output logic        sdclk,
	output logic        sddo
);

	import zx_pkg::*;

	z80_bus_t bus;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;

	////////////////////////////////////////////////////////////////////////////
	// Z80 bus into fclk domain
	////////////////////////////////////////////////////////////////////////////

	z80_strobes i_strobes (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.a      (a),
		.zd_in  (zd_in),
		.bus    (bus)
	);

	zports i_zports (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.bus     (bus),
		.wb_rsp  (wb_rsp),
		.wb_req  (wb_req),
		.zd_out  (zd_out),
		.zd_oe   (zd_oe),
		.border  (border),
		.turbo   (turbo),
		.memconf (memconf),
		.beep    (beep),
		.sdcs_n  (sdcs_n),
		.wait_n  (wait_n)
	);

	// SD card link
	sd_spi i_sd_spi (
		.fclk   (fclk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.sddi   (sddi),
		.wb_rsp (wb_rsp),
		.sdclk  (sdclk),
		.sddo   (sddo)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic fclk,
	output logic rst_n
);

	// 20 ns period
	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	// reset held for 5 clock cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;
	end

endmodule

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

	import zx_pkg::*;

	localparam int HOLD_CYCLES = 4;
	localparam int IDLE_CYCLES = 4;

	typedef enum logic [1:0] {OP_NONE, OP_WR, OP_RD, OP_INTA} op_e;
	typedef enum logic [3:0] {
		CHK_ZD, CHK_NO_OE, CHK_BORDER, CHK_MEMCONF, CHK_TURBO,
		CHK_BEEP, CHK_SDCS, CHK_WAIT, CHK_SD_TX, CHK_WAIT_SEEN
	} chk_e;

	typedef struct packed {
		op_e         op;
		chk_e        chk;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
	} entry_t;

	logic        fclk, rst_n;
	logic        iorq_n, rd_n, wr_n, m1_n;
	logic [15:0] a;
	logic [7:0]  zd_in;
	logic        sddi;
	logic [7:0]  zd_out, border, memconf;
	logic [1:0]  turbo;
	logic        zd_oe, wait_n, beep, sdcs_n, sdclk, sddo;

	entry_t      tests[$];
	string       names[$];
	int          errors = 0;
	int          passes = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	// SD card model state
	logic [7:0]  card_byte = 8'h00;
	logic [7:0]  card_sh = 8'h00;
	logic [7:0]  sd_tx_cap = 8'h00;
	logic        sdclk_prev = 1'b0;
	int          arm_cnt = 0;
	int          armed_cnt = 0;
	int          wait_low_cnt = 0;
	int          wait_base = 0;

	tb_clock i_clock (
		.fclk  (fclk),
		.rst_n (rst_n)
	);

	zx_port_top i_dut (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.iorq_n  (iorq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.m1_n    (m1_n),
		.a       (a),
		.zd_in   (zd_in),
		.sddi    (sddi),
		.zd_out  (zd_out),
		.zd_oe   (zd_oe),
		.wait_n  (wait_n),
		.border  (border),
		.turbo   (turbo),
		.memconf (memconf),
		.beep    (beep),
		.sdcs_n  (sdcs_n),
		.sdclk   (sdclk),
		.sddo    (sddo)
	);

	////////////////////////////////////////////////////////////////////////////
	// SD card model
	////////////////////////////////////////////////////////////////////////////

	assign sddi = card_sh[7];

	// sdclk edges seen on the falling fclk edge
	always @(negedge fclk) begin
		if (!wait_n)
			wait_low_cnt = wait_low_cnt + 1;
		if (arm_cnt != armed_cnt) begin
			card_sh   = card_byte;
			armed_cnt = arm_cnt;
		end else if (sdclk_prev && !sdclk) begin
			card_sh = {card_sh[6:0], 1'b0};
		end
		// card takes sddo on rising sdclk
		if (!sdclk_prev && sdclk)
			sd_tx_cap = {sd_tx_cap[6:0], sddo};
		sdclk_prev = sdclk;
	end

	always @(posedge fclk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout, the DUT did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_test(input string name, input op_e op, input chk_e chk,
			input logic [15:0] addr, input logic [7:0] data, input logic [7:0] exp);
		entry_t e;
		e.op   = op;
		e.chk  = chk;
		e.addr = addr;
		e.data = data;
		e.exp  = exp;
		tests.push_back(e);
		names.push_back(name);
	endtask

	// Z80 I/O or intack cycle stretched by wait_n
	task automatic run_bus_cycle(input op_e op, input logic [15:0] addr,
			input logic [7:0] data, input logic need_data,
			output logic [7:0] rdata, output logic oe);
		@(negedge fclk);
		a      = addr;
		zd_in  = data;
		iorq_n = 1'b0;
		m1_n   = (op == OP_INTA) ? 1'b0 : 1'b1;
		rd_n   = (op == OP_RD) ? 1'b0 : 1'b1;
		wr_n   = (op == OP_WR) ? 1'b0 : 1'b1;
		repeat (HOLD_CYCLES) @(negedge fclk);
		while (!wait_n)
			@(negedge fclk);
		if (need_data) begin
			while (!zd_oe)
				@(negedge fclk);
		end
		rdata  = zd_out;
		oe     = zd_oe;
		iorq_n = 1'b1;
		m1_n   = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		repeat (IDLE_CYCLES) @(negedge fclk);
	endtask

	function automatic logic [7:0] observed(input chk_e chk, input logic [7:0] rdata,
			input logic oe);
		case (chk)
			CHK_ZD:        return rdata;
			CHK_NO_OE:     return {7'b0, oe};
			CHK_BORDER:    return border;
			CHK_MEMCONF:   return memconf;
			CHK_TURBO:     return {6'b0, turbo};
			CHK_BEEP:      return {7'b0, beep};
			CHK_SDCS:      return {7'b0, sdcs_n};
			CHK_WAIT:      return {7'b0, wait_n};
			CHK_SD_TX:     return sd_tx_cap;
			CHK_WAIT_SEEN: return {7'b0, wait_low_cnt != wait_base};
			default:       return 8'h00;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus table and run
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] seed;
		logic [7:0]  rnd[$];
		logic [7:0]  rdata;
		logic [7:0]  got;
		logic        oe;
		logic        need_data;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		a      = 16'h0000;
		zd_in  = 8'h00;
		seed   = 32'hd3f7_4904;
		for (int i = 0; i < 8; i++) begin
			seed = lcg_next(seed);
			rnd.push_back(seed[31:24]);
		end

		add_test("rst_sysconf", OP_RD, CHK_ZD, 16'h20AF, 8'h00, 8'h00);
		add_test("rst_memconf", OP_RD, CHK_ZD, 16'h21AF, 8'h00, 8'h00);
		add_test("rst_border", OP_RD, CHK_ZD, 16'h0FAF, 8'h00, 8'h00);
		add_test("rst_turbo", OP_NONE, CHK_TURBO, 16'h0000, 8'h00, 8'h00);
		add_test("rst_sdcs", OP_NONE, CHK_SDCS, 16'h0000, 8'h00, 8'h01);
		add_test("rst_wait", OP_NONE, CHK_WAIT, 16'h0000, 8'h00, 8'h01);
		add_test("rst_beep", OP_NONE, CHK_BEEP, 16'h0000, 8'h00, 8'h00);
		add_test("rst_intack", OP_INTA, CHK_ZD, 16'h0000, 8'h00, 8'hFF);
		add_test("wr_border", OP_WR, CHK_BORDER, 16'h0FAF, rnd[0], rnd[0]);
		add_test("rd_border", OP_RD, CHK_ZD, 16'h0FAF, 8'h00, rnd[0]);
		add_test("wr_sysconf", OP_WR, CHK_TURBO, 16'h20AF, rnd[1], {6'b0, rnd[1][1:0]});
		add_test("rd_sysconf", OP_RD, CHK_ZD, 16'h20AF, 8'h00, rnd[1]);
		add_test("wr_memconf", OP_WR, CHK_MEMCONF, 16'h21AF, rnd[2], rnd[2]);
		add_test("rd_memconf", OP_RD, CHK_ZD, 16'h21AF, 8'h00, rnd[2]);
		add_test("wr_fe_border", OP_WR, CHK_BORDER, 16'h00FE, rnd[3],
			{5'b11110, rnd[3][2:0]});
		add_test("fe_beep", OP_NONE, CHK_BEEP, 16'h0000, 8'h00, {7'b0, rnd[3][4]});
		add_test("rd_fe", OP_RD, CHK_NO_OE, 16'h00FE, 8'h00, 8'h00);
		// a non-SD write never stretches the bus
		add_test("wr_im2vect", OP_WR, CHK_WAIT_SEEN, 16'h24AF, rnd[4], 8'h00);
		add_test("intack_im2vect", OP_INTA, CHK_ZD, 16'h0000, 8'h00, rnd[4]);
		add_test("sd_cs_low", OP_WR, CHK_SDCS, 16'h0077, rnd[5] & 8'hFD, 8'h00);
		add_test("sd_write", OP_WR, CHK_SD_TX, 16'h0057, rnd[6], rnd[6]);
		add_test("sd_wait_seen", OP_NONE, CHK_WAIT_SEEN, 16'h0000, 8'h00, 8'h01);
		add_test("sd_read", OP_RD, CHK_ZD, 16'h0057, 8'h00, rnd[7]);
		add_test("sd_wait_idle", OP_NONE, CHK_WAIT, 16'h0000, 8'h00, 8'h01);

		card_byte   = rnd[7];
		cycle_limit = 40 * tests.size() + 20;

		wait (rst_n === 1'b1);
		repeat (2) @(negedge fclk);

		for (int t = 0; t < tests.size(); t++) begin
			rdata = 8'h00;
			oe    = 1'b0;
			if (tests[t].op == OP_NONE) begin
				repeat (IDLE_CYCLES) @(negedge fclk);
			end else begin
				wait_base = wait_low_cnt;
				if (tests[t].op == OP_WR && tests[t].addr[7:0] == 8'h57)
					arm_cnt = arm_cnt + 1;
				need_data = (tests[t].chk == CHK_ZD);
				run_bus_cycle(tests[t].op, tests[t].addr, tests[t].data, need_data,
					rdata, oe);
			end
			got = observed(tests[t].chk, rdata, oe);
			assert (got == tests[t].exp) begin
				$display("pass  %s", names[t]);
				passes++;
			end else begin
				$display("ERROR %s expected %02h actual %02h", names[t], tests[t].exp, got);
				errors++;
			end
		end

		$display("tests run %0d, passed %0d, failed %0d", tests.size(), passes, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
design/zx_pkg.sv
design/z80_strobes.sv
design/zports.sv
design/sd_spi.sv
design/zx_port_top.sv
test/tb_clock.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
